/* design/core_cfg_pkg.sv */
package core_cfg_pkg;

   localparam int xlen         = 16;  // data width
   localparam int num_regs     = 8;   // architectural registers
   localparam int reg_addr_len = 3;
   localparam int rob_size     = 8;   // reorder buffer entries
   localparam int rob_tag_len  = 3;
   localparam int num_rs       = 4;   // reservation stations
   localparam int rs_idx_len   = $clog2(num_rs);
   localparam int mul_latency  = 3;   // execute cycles for a multiply
   localparam int lat_len      = $clog2(mul_latency + 1);

endpackage

/* design/core_isa_pkg.sv */
package core_isa_pkg;

   typedef enum logic [2:0] {
      op_li  = 3'd0,  // load immediate
      op_add = 3'd1,
      op_sub = 3'd2,
      op_and = 3'd3,
      op_xor = 3'd4,
      op_mul = 3'd5
   } opcode_e;

   typedef enum logic [1:0] {
      rob_free = 2'd0,
      rob_wait = 2'd1,  // allocated, result not yet on the cdb
      rob_done = 2'd2
   } rob_state_e;

   // cycles spent in execute once both operands are present
   function automatic logic [core_cfg_pkg::lat_len-1:0] exec_latency(opcode_e op);
      if (op == op_mul) begin
         return core_cfg_pkg::lat_len'(core_cfg_pkg::mul_latency);
      end
      return core_cfg_pkg::lat_len'(1);
   endfunction

endpackage

/* design/map_table.sv */
`timescale 1ns/10ps

module map_table (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] src1,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] src2,
   input  logic                                 rename_en,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] rename_reg,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  rename_tag,
   input  logic                                 commit_valid,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  commit_tag,
   output logic                                 src1_pending,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  src1_tag,
   output logic                                 src2_pending,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  src2_tag
);
   import core_cfg_pkg::*;

   logic [num_regs-1:0]    pending;
   logic [rob_tag_len-1:0] tag [num_regs];

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= '0;
      end else begin
         // only the newest writer of a register may clear it
         for (int r = 0; r < num_regs; r++) begin
            if (commit_valid && pending[r] && tag[r] == commit_tag) begin
               pending[r] <= 1'b0;
            end
         end
         if (rename_en) begin
            pending[rename_reg] <= 1'b1;  // wins over a same-cycle clear
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rename_en) begin
         tag[rename_reg] <= rename_tag;
      end
   end

   assign src1_pending = pending[src1];
   assign src1_tag     = tag[src1];
   assign src2_pending = pending[src2];
   assign src2_tag     = tag[src2];

endmodule

/* design/dispatcher.sv */
`timescale 1ns/10ps

module dispatcher (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 insn_valid,
   input  core_isa_pkg::opcode_e                insn_op,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] insn_dest,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] insn_src1,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] insn_src2,
   input  logic [core_cfg_pkg::xlen-1:0]         insn_imm,
   output logic                                 insn_ready,
   output logic [core_cfg_pkg::reg_addr_len-1:0] src1,
   output logic [core_cfg_pkg::reg_addr_len-1:0] src2,
   output logic                                 rename_en,
   output logic [core_cfg_pkg::reg_addr_len-1:0] rename_reg,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  rename_tag,
   input  logic                                 src1_pending,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  src1_tag,
   input  logic                                 src2_pending,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  src2_tag,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  alloc_tag,
   input  logic                                 rob_full,
   output logic                                 alloc,
   output logic [core_cfg_pkg::reg_addr_len-1:0] alloc_reg,
   input  logic                                 src1_rob_done,
   input  logic [core_cfg_pkg::xlen-1:0]         src1_rob_value,
   input  logic                                 src2_rob_done,
   input  logic [core_cfg_pkg::xlen-1:0]         src2_rob_value,
   input  logic [core_cfg_pkg::xlen-1:0]         reg_value1,
   input  logic [core_cfg_pkg::xlen-1:0]         reg_value2,
   input  logic [core_cfg_pkg::num_rs-1:0]       rs_busy,
   output logic [core_cfg_pkg::num_rs-1:0]       rs_load,
   output core_isa_pkg::opcode_e                entry_op,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  entry_tag,
   output logic                                 entry_src1_ready,
   output logic [core_cfg_pkg::xlen-1:0]         entry_src1_value,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  entry_src1_tag,
   output logic                                 entry_src2_ready,
   output logic [core_cfg_pkg::xlen-1:0]         entry_src2_value,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  entry_src2_tag,
   input  logic                                 cdb_valid,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  cdb_tag,
   input  logic [core_cfg_pkg::xlen-1:0]         cdb_value
);
   import core_cfg_pkg::*;
   import core_isa_pkg::*;

   logic                    d_valid;  // dispatch register holds an instruction
   opcode_e                 d_op;
   logic [reg_addr_len-1:0] d_dest;
   logic [reg_addr_len-1:0] d_src1;
   logic [reg_addr_len-1:0] d_src2;
   logic [xlen-1:0]         d_imm;
   logic [num_rs-1:0]       free_oh;
   logic                    dispatch;

   // r0, then register file, then rob, then a cdb beat this cycle
   function automatic void pick_operand(
      input  logic [reg_addr_len-1:0] addr,
      input  logic                    pending,
      input  logic [rob_tag_len-1:0]  tag,
      input  logic                    rob_done,
      input  logic [xlen-1:0]         rob_value,
      input  logic [xlen-1:0]         reg_value,
      output logic                    rdy,
      output logic [xlen-1:0]         val
   );
      rdy = 1'b1;
      val = '0;
      if (addr != '0) begin
         if (!pending) begin
            val = reg_value;
         end else if (rob_done) begin
            val = rob_value;
         end else if (cdb_valid && cdb_tag == tag) begin
            val = cdb_value;
         end else begin
            rdy = 1'b0;  // station waits for the tag
         end
      end
   endfunction

   assign free_oh    = ~rs_busy & (rs_busy + 1'b1);  // lowest idle station
   assign dispatch   = d_valid && (|free_oh) && !rob_full;
   assign insn_ready = !d_valid || dispatch;

   always_ff @(posedge clk) begin
      if (reset) begin
         d_valid <= 1'b0;
      end else if (insn_valid && insn_ready) begin
         d_valid <= 1'b1;
      end else if (dispatch) begin
         d_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (insn_valid && insn_ready) begin
         d_op   <= insn_op;
         d_dest <= insn_dest;
         d_src1 <= insn_src1;
         d_src2 <= insn_src2;
         d_imm  <= insn_imm;
      end
   end

   assign src1       = d_src1;
   assign src2       = d_src2;
   assign rename_en  = dispatch && d_dest != '0;  // r0 keeps no mapping
   assign rename_reg = d_dest;
   assign rename_tag = alloc_tag;
   assign alloc      = dispatch;
   assign alloc_reg  = d_dest;
   assign rs_load    = dispatch ? free_oh : '0;

   assign entry_op       = d_op;
   assign entry_tag      = alloc_tag;
   assign entry_src1_tag = src1_tag;
   assign entry_src2_tag = src2_tag;

   always_comb begin
      pick_operand(d_src1, src1_pending, src1_tag, src1_rob_done, src1_rob_value,
                   reg_value1, entry_src1_ready, entry_src1_value);
      pick_operand(d_src2, src2_pending, src2_tag, src2_rob_done, src2_rob_value,
                   reg_value2, entry_src2_ready, entry_src2_value);
      if (d_op == op_li) begin
         entry_src1_ready = 1'b1;
         entry_src1_value = d_imm;  // immediate rides in src1
         entry_src2_ready = 1'b1;
         entry_src2_value = '0;
      end
   end

endmodule

/* design/reservation_station.sv */
`timescale 1ns/10ps

module reservation_station (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                load,
   input  core_isa_pkg::opcode_e               entry_op,
   input  logic [core_cfg_pkg::rob_tag_len-1:0] entry_tag,
   input  logic                                entry_src1_ready,
   input  logic [core_cfg_pkg::xlen-1:0]        entry_src1_value,
   input  logic [core_cfg_pkg::rob_tag_len-1:0] entry_src1_tag,
   input  logic                                entry_src2_ready,
   input  logic [core_cfg_pkg::xlen-1:0]        entry_src2_value,
   input  logic [core_cfg_pkg::rob_tag_len-1:0] entry_src2_tag,
   input  logic                                cdb_valid,
   input  logic [core_cfg_pkg::rob_tag_len-1:0] cdb_tag,
   input  logic [core_cfg_pkg::xlen-1:0]        cdb_value,
   input  logic                                grant,
   output logic                                busy,
   output logic                                done_req,
   output logic [core_cfg_pkg::xlen-1:0]        result,
   output logic [core_cfg_pkg::rob_tag_len-1:0] result_tag
);
   import core_cfg_pkg::*;
   import core_isa_pkg::*;

   typedef enum logic [1:0] {st_idle, st_wait, st_exec, st_done} rs_state_e;

   rs_state_e              state;
   opcode_e                op;
   logic [rob_tag_len-1:0] dest_tag;
   logic [lat_len-1:0]     cnt;  // execute cycles left
   logic                   src1_ready;
   logic                   src2_ready;
   logic [xlen-1:0]        src1_value;
   logic [xlen-1:0]        src2_value;
   logic [rob_tag_len-1:0] src1_tag;
   logic [rob_tag_len-1:0] src2_tag;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (load) state <= st_wait;
            st_wait: if (src1_ready && src2_ready) state <= st_exec;
            st_exec: if (cnt == 1) state <= st_done;
            st_done: if (grant) state <= st_idle;  // leaves on the cdb beat
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         op         <= entry_op;
         dest_tag   <= entry_tag;
         src1_ready <= entry_src1_ready;
         src1_value <= entry_src1_value;
         src1_tag   <= entry_src1_tag;
         src2_ready <= entry_src2_ready;
         src2_value <= entry_src2_value;
         src2_tag   <= entry_src2_tag;
      end else if (state == st_wait) begin
         if (!src1_ready && cdb_valid && cdb_tag == src1_tag) begin
            src1_ready <= 1'b1;
            src1_value <= cdb_value;
         end
         if (!src2_ready && cdb_valid && cdb_tag == src2_tag) begin
            src2_ready <= 1'b1;
            src2_value <= cdb_value;
         end
         if (src1_ready && src2_ready) begin
            cnt <= exec_latency(op);
         end
      end else if (state == st_exec) begin
         cnt <= cnt - 1'b1;
      end
   end

   // operands are stable from exec onwards
   always_comb begin
      case (op)
         op_li:   result = src1_value;
         op_add:  result = src1_value + src2_value;
         op_sub:  result = src1_value - src2_value;
         op_and:  result = src1_value & src2_value;
         op_xor:  result = src1_value ^ src2_value;
         op_mul:  result = src1_value * src2_value;  // low half only
         default: result = '0;
      endcase
   end

   assign result_tag = dest_tag;
   assign busy       = state != st_idle;
   assign done_req   = state == st_done;

endmodule

/* design/cdb_arbiter.sv */
`timescale 1ns/10ps

module cdb_arbiter (
   input  logic                                                          clk,
   input  logic                                                          reset,
   input  logic [core_cfg_pkg::num_rs-1:0]                               done_req,
   input  logic [core_cfg_pkg::num_rs-1:0][core_cfg_pkg::xlen-1:0]        result,
   input  logic [core_cfg_pkg::num_rs-1:0][core_cfg_pkg::rob_tag_len-1:0] result_tag,
   output logic [core_cfg_pkg::num_rs-1:0]                               grant,
   output logic                                                          cdb_valid,
   output logic [core_cfg_pkg::rob_tag_len-1:0]                           cdb_tag,
   output logic [core_cfg_pkg::xlen-1:0]                                  cdb_value
);
   import core_cfg_pkg::*;

   logic [rs_idx_len-1:0] last;  // most recently granted station
   logic [rs_idx_len-1:0] sel;

   // scan from the farthest so the station right after last wins
   always_comb begin
      logic [rs_idx_len-1:0] idx;
      grant = '0;
      sel   = last;
      for (int i = num_rs; i >= 1; i--) begin
         idx = last + rs_idx_len'(i);
         if (done_req[idx]) begin
            grant      = '0;
            grant[idx] = 1'b1;
            sel        = idx;
         end
      end
   end

   assign cdb_valid = |done_req;
   assign cdb_tag   = result_tag[sel];
   assign cdb_value = result[sel];

   always_ff @(posedge clk) begin
      if (reset) begin
         last <= rs_idx_len'(num_rs - 1);  // station 0 first
      end else if (cdb_valid) begin
         last <= sel;
      end
   end

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 alloc,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] alloc_reg,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  alloc_tag,
   output logic                                 rob_full,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  src1_tag,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  src2_tag,
   output logic                                 src1_rob_done,
   output logic [core_cfg_pkg::xlen-1:0]         src1_rob_value,
   output logic                                 src2_rob_done,
   output logic [core_cfg_pkg::xlen-1:0]         src2_rob_value,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] src1,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] src2,
   output logic [core_cfg_pkg::xlen-1:0]         reg_value1,
   output logic [core_cfg_pkg::xlen-1:0]         reg_value2,
   input  logic                                 cdb_valid,
   input  logic [core_cfg_pkg::rob_tag_len-1:0]  cdb_tag,
   input  logic [core_cfg_pkg::xlen-1:0]         cdb_value,
   output logic                                 commit_valid,
   output logic [core_cfg_pkg::reg_addr_len-1:0] commit_reg,
   output logic [core_cfg_pkg::xlen-1:0]         commit_value,
   output logic [core_cfg_pkg::rob_tag_len-1:0]  commit_tag
);
   import core_cfg_pkg::*;
   import core_isa_pkg::*;

   rob_state_e              state [rob_size];
   logic [reg_addr_len-1:0] dest  [rob_size];
   logic [xlen-1:0]         value [rob_size];
   logic [xlen-1:0]         regs  [num_regs];  // architectural register file
   logic [rob_tag_len-1:0]  head;
   logic [rob_tag_len-1:0]  tail;
   logic [rob_tag_len:0]    count;

   assign alloc_tag = tail;
   assign rob_full  = count == rob_size;

   // head retires on the edge closing this cycle
   assign commit_valid = state[head] == rob_done;
   assign commit_reg   = dest[head];
   assign commit_value = value[head];
   assign commit_tag   = head;

   assign src1_rob_done  = state[src1_tag] == rob_done;
   assign src1_rob_value = value[src1_tag];
   assign src2_rob_done  = state[src2_tag] == rob_done;
   assign src2_rob_value = value[src2_tag];

   assign reg_value1 = (src1 == '0) ? '0 : regs[src1];
   assign reg_value2 = (src2 == '0) ? '0 : regs[src2];

   always_ff @(posedge clk) begin
      if (reset) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         for (int i = 0; i < rob_size; i++) begin
            state[i] <= rob_free;
         end
      end else begin
         if (alloc) begin
            state[tail] <= rob_wait;
            tail        <= tail + 1'b1;  // wraps at rob_size
         end
         if (cdb_valid) begin
            state[cdb_tag] <= rob_done;
         end
         if (commit_valid) begin
            state[head] <= rob_free;
            head        <= head + 1'b1;
         end
         count <= count + alloc - commit_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         dest[tail] <= alloc_reg;
      end
      if (cdb_valid) begin
         value[cdb_tag] <= cdb_value;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < num_regs; r++) begin
            regs[r] <= '0;
         end
      end else if (commit_valid && commit_reg != '0) begin
         regs[commit_reg] <= commit_value;
      end
   end

endmodule

/* design/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 insn_valid,
   input  core_isa_pkg::opcode_e                insn_op,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] insn_dest,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] insn_src1,
   input  logic [core_cfg_pkg::reg_addr_len-1:0] insn_src2,
   input  logic [core_cfg_pkg::xlen-1:0]         insn_imm,
   output logic                                 insn_ready,
   output logic                                 commit_valid,
   output logic [core_cfg_pkg::reg_addr_len-1:0] commit_reg,
   output logic [core_cfg_pkg::xlen-1:0]         commit_value
);
   import core_cfg_pkg::*;
   import core_isa_pkg::*;

   // rename and operand lookup
   logic [reg_addr_len-1:0] src1;
   logic [reg_addr_len-1:0] src2;
   logic                    rename_en;
   logic [reg_addr_len-1:0] rename_reg;
   logic [rob_tag_len-1:0]  rename_tag;
   logic                    src1_pending;
   logic [rob_tag_len-1:0]  src1_tag;
   logic                    src2_pending;
   logic [rob_tag_len-1:0]  src2_tag;
   logic                    src1_rob_done;
   logic [xlen-1:0]         src1_rob_value;
   logic                    src2_rob_done;
   logic [xlen-1:0]         src2_rob_value;
   logic [xlen-1:0]         reg_value1;
   logic [xlen-1:0]         reg_value2;

   // rob allocation and retirement
   logic [rob_tag_len-1:0]  alloc_tag;
   logic                    rob_full;
   logic                    alloc;
   logic [reg_addr_len-1:0] alloc_reg;
   logic [rob_tag_len-1:0]  commit_tag;

   // shared station entry bus
   logic [num_rs-1:0]       rs_busy;
   logic [num_rs-1:0]       rs_load;
   opcode_e                 entry_op;
   logic [rob_tag_len-1:0]  entry_tag;
   logic                    entry_src1_ready;
   logic [xlen-1:0]         entry_src1_value;
   logic [rob_tag_len-1:0]  entry_src1_tag;
   logic                    entry_src2_ready;
   logic [xlen-1:0]         entry_src2_value;
   logic [rob_tag_len-1:0]  entry_src2_tag;

   // completion and common data bus
   logic [num_rs-1:0]                  done_req;
   logic [num_rs-1:0][xlen-1:0]        result;
   logic [num_rs-1:0][rob_tag_len-1:0] result_tag;
   logic [num_rs-1:0]                  grant;
   logic                               cdb_valid;
   logic [rob_tag_len-1:0]             cdb_tag;
   logic [xlen-1:0]                    cdb_value;

   map_table u_map_table (.*);

   dispatcher u_dispatcher (.*);

   reorder_buffer u_rob (.*);

   cdb_arbiter u_arbiter (.*);

   for (genvar i = 0; i < num_rs; i++) begin : g_rs
      reservation_station u_rs (
         .*,
         .load       (rs_load[i]),
         .grant      (grant[i]),
         .busy       (rs_busy[i]),
         .done_req   (done_req[i]),
         .result     (result[i]),
         .result_tag (result_tag[i])
      );
   end

endmodule

/* verification/ooo_core_tb.sv */
`timescale 1ns/10ps

module ooo_core_tb;
   import core_cfg_pkg::*;
   import core_isa_pkg::*;

   localparam int accept_limit = 200;  // cycles one instruction may wait at the input
   localparam int drain_limit  = 400;

   typedef struct packed {
      logic [reg_addr_len-1:0] dest;
      logic [xlen-1:0]         value;
   } commit_t;

   logic                    clk = 1'b0;
   logic                    reset;
   logic                    insn_valid;
   opcode_e                 insn_op;
   logic [reg_addr_len-1:0] insn_dest;
   logic [reg_addr_len-1:0] insn_src1;
   logic [reg_addr_len-1:0] insn_src2;
   logic [xlen-1:0]         insn_imm;
   logic                    insn_ready;
   logic                    commit_valid;
   logic [reg_addr_len-1:0] commit_reg;
   logic [xlen-1:0]         commit_value;

   logic [31:0]     rng;
   logic [xlen-1:0] gold_regs [num_regs];  // architectural state in acceptance order
   commit_t         expect_q [$];          // accepted, not yet retired
   int              errors;
   int              accept_count;
   int              commit_count;
   int              stall_cycles;
   logic            timed_out;

   ooo_core uut (.*);

   initial begin
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // opcode rules, results cut to xlen
   function automatic logic [xlen-1:0] model_result(opcode_e op, logic [xlen-1:0] a,
                                                    logic [xlen-1:0] b, logic [xlen-1:0] imm);
      case (op)
         op_li:   return imm;
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_xor:  return a ^ b;
         op_mul:  return a * b;
         default: return '0;
      endcase
   endfunction

   function automatic void record_accept(opcode_e op, logic [reg_addr_len-1:0] dest,
                                         logic [reg_addr_len-1:0] s1,
                                         logic [reg_addr_len-1:0] s2, logic [xlen-1:0] imm);
      commit_t c;
      c.dest  = dest;
      c.value = model_result(op, gold_regs[s1], gold_regs[s2], imm);
      expect_q.push_back(c);
      if (dest != '0) begin
         gold_regs[dest] = c.value;  // r0 stays zero
      end
      accept_count++;
   endfunction

   task automatic send_insn(input opcode_e op, input logic [reg_addr_len-1:0] dest,
                            input logic [reg_addr_len-1:0] s1,
                            input logic [reg_addr_len-1:0] s2, input logic [xlen-1:0] imm);
      int   waited;
      logic taken;
      insn_valid = 1'b1;
      insn_op    = op;
      insn_dest  = dest;
      insn_src1  = s1;
      insn_src2  = s2;
      insn_imm   = imm;
      waited     = 0;
      taken      = 1'b0;
      while (!taken && waited < accept_limit) begin
         @(negedge clk);
         taken = insn_ready;  // accepted on the coming edge
         @(posedge clk);
         #2;
         waited++;
      end
      insn_valid = 1'b0;
      if (taken) begin
         record_accept(op, dest, s1, s2, imm);
      end else begin
         timed_out = 1'b1;
         $display("retirement stalled: instruction %0d was never accepted", accept_count);
      end
   endtask

   task automatic idle_cycle();
      insn_valid = 1'b0;
      @(posedge clk);
      #2;
   endtask

   task automatic random_mix(input int n);
      logic [31:0] r;
      opcode_e     op;
      for (int i = 0; i < n && !timed_out; i++) begin
         r = next_rand();
         if (r[1:0] == 2'b00) begin
            idle_cycle();
         end
         op = opcode_e'(3'((r >> 2) % 6));
         if (r[31:30] == 2'b11) begin
            op = op_mul;  // more long-latency producers
         end
         send_insn(op, r[10:8], r[13:11], r[16:14], xlen'(next_rand()));
      end
   endtask

   // dependent chain behind multiplies, with a write to r0 and a read of it
   task automatic mul_chain();
      send_insn(op_li,  3'd1, 3'd0, 3'd0, 16'h0003);
      send_insn(op_li,  3'd2, 3'd0, 3'd0, 16'h0005);
      send_insn(op_mul, 3'd3, 3'd1, 3'd2, '0);
      send_insn(op_add, 3'd4, 3'd3, 3'd1, '0);
      send_insn(op_mul, 3'd5, 3'd4, 3'd3, '0);
      send_insn(op_sub, 3'd6, 3'd5, 3'd2, '0);
      send_insn(op_xor, 3'd7, 3'd6, 3'd5, '0);
      send_insn(op_and, 3'd0, 3'd7, 3'd6, '0);
      send_insn(op_add, 3'd1, 3'd0, 3'd7, '0);
      send_insn(op_mul, 3'd2, 3'd1, 3'd1, '0);
   endtask

   // independent multiplies back to back fill every station
   task automatic fill_stations();
      send_insn(op_li, 3'd6, 3'd0, 3'd0, 16'h1234);
      send_insn(op_li, 3'd7, 3'd0, 3'd0, 16'h00a7);
      for (int i = 0; i < 10 && !timed_out; i++) begin
         send_insn(op_mul, reg_addr_len'(1 + i % 5), 3'd6, 3'd7, '0);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (expect_q.size() != 0 && waited < drain_limit) begin
         @(posedge clk);
         waited++;
      end
      if (expect_q.size() != 0) begin
         timed_out = 1'b1;
         $display("retirement stalled: %0d instructions never retired", expect_q.size());
      end
   endtask

   reset_state_chk: assert property (@(negedge clk)
      (reset || $fell(reset)) |-> (!commit_valid && insn_ready))
      else begin
         errors++;
         $display("[ERROR] reset_state: expected commit_valid=0 insn_ready=1, got %b %b",
                  commit_valid, insn_ready);
      end

   known_chk: assert property (@(negedge clk) disable iff (reset)
      !$isunknown({commit_valid, insn_ready}))
      else begin
         errors++;
         $display("commit_valid or insn_ready is unknown outside reset");
      end

   // one retirement per cycle with commit_valid high
   always @(negedge clk) begin
      commit_t c;
      if (!reset && commit_valid) begin
         commit_count++;  // every pulse, matched or not
         if (expect_q.size() == 0) begin
            errors++;
            $display("commit_valid was high with no accepted instruction left to retire");
         end else begin
            c = expect_q.pop_front();
            program_order_chk: assert (commit_reg == c.dest) else begin
               errors++;
               $display("[ERROR] program_order: expected r%0d, got r%0d", c.dest, commit_reg);
            end
            result_value_chk: assert (commit_value == c.value) else begin
               errors++;
               $display("[ERROR] result_value: expected %h, got %h", c.value, commit_value);
            end
         end
      end
   end

   always @(negedge clk) begin
      if (!reset && insn_valid && !insn_ready) begin
         stall_cycles++;
      end
   end

   initial begin
      rng        = 32'hd5037020;
      timed_out  = 1'b0;
      reset      = 1'b1;
      insn_valid = 1'b0;
      insn_op    = op_li;
      insn_dest  = '0;
      insn_src1  = '0;
      insn_src2  = '0;
      insn_imm   = '0;
      for (int r = 0; r < num_regs; r++) begin
         gold_regs[r] = '0;
      end
      repeat (3) @(posedge clk);
      #2;
      reset = 1'b0;
      mul_chain();
      if (!timed_out) random_mix(80);
      if (!timed_out) fill_stations();
      if (!timed_out) random_mix(40);
      if (!timed_out) wait_drain();
      if (!timed_out) begin
         repeat (5) @(posedge clk);  // nothing may retire after the drain
         completeness_chk: assert (commit_count == accept_count) else begin
            errors++;
            $display("[ERROR] completeness: expected %0d commits, got %0d",
                     accept_count, commit_count);
         end
         back_pressure_chk: assert (stall_cycles > 0) else begin
            errors++;
            $display("insn_ready never dropped while an instruction was waiting");
         end
      end
      $display("errors: %0d  accepted: %0d  committed: %0d  stall cycles: %0d",
               errors, accept_count, commit_count, stall_cycles);
      if (errors == 0 && !timed_out) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* sim.f */
design/core_cfg_pkg.sv
design/core_isa_pkg.sv
design/map_table.sv
design/dispatcher.sv
design/reservation_station.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/ooo_core.sv
verification/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - design/core_cfg_pkg.sv
  - design/core_isa_pkg.sv
  - design/map_table.sv
  - design/dispatcher.sv
  - design/reservation_station.sv
  - design/cdb_arbiter.sv
  - design/reorder_buffer.sv
  - design/ooo_core.sv
  - target: simulation
    files:
      - verification/ooo_core_tb.sv
